// ==== cpuPkg.sv ====
// Encodings above opPassB are not decoded and give a zero result with the carry cleared
`default_nettype none

package cpuPkg;

  // ALU operation code as delivered by decode
  typedef enum logic [3:0] {
    opAdd   = 4'd0, // A + B
    opAdc   = 4'd1, // A + B + stored carry
    opSub   = 4'd2, // A - B, carry set means no borrow
    opAnd   = 4'd3,
    opOr    = 4'd4,
    opXor   = 4'd5,
    opShl   = 4'd6, // A shifted left by one, MSB into carry
    opShr   = 4'd7, // A shifted right by one, LSB into carry
    opPassB = 4'd8  // Result is operand B
  } aluOpT;

  // Special register indices
  localparam int dataSegIdx  = 14; // Data segment register
  localparam int stackPtrIdx = 15; // Stack pointer

  // True for the operation that consumes the stored carry flag
  function automatic logic readsCarry(input aluOpT op);
    logic uses;
    uses = (op == opAdc);
    return uses;
  endfunction

  // Logic operations and the pass-through leave carry cleared
  function automatic logic isLogicOp(input aluOpT op);
    logic logicOp;
    case (op)
      opAnd,
      opOr,
      opXor,
      opPassB: logicOp = 1'b1;
      default: logicOp = 1'b0;
    endcase
    return logicOp;
  endfunction

endpackage

`default_nettype wire

// ==== aluUnit.sv ====
// Purely combinational; dataWidth must be at least 4 and shifts move operand A by one bit
`timescale 1ns/1ps
`default_nettype none

module aluUnit import cpuPkg::*; #(
  parameter int dataWidth = 16
) (
  input  wire [dataWidth-1:0]  opA,
  input  wire [dataWidth-1:0]  opB,
  input  wire aluOpT           aluOp,
  input  wire                  carryIn,   // Stored carry flag
  output logic [dataWidth-1:0] aluResult,
  output logic                 carryOut,
  output logic                 zeroOut,
  output logic                 negOut
);

  logic [dataWidth:0]   wide;   // Result with the carry bit on top
  logic [dataWidth-1:0] addB;   // Adder operand B, inverted for subtract
  logic                 addCin; // Adder carry in
  logic [dataWidth:0]   sum;

  // Shared adder for add, add with carry and subtract
  always_comb begin
    if (aluOp == opSub) begin
      addB   = ~opB;
      addCin = 1'b1; // Two's complement of B
    end else begin
      addB   = opB;
      addCin = readsCarry(aluOp) & carryIn;
    end
    sum = {1'b0, opA} + {1'b0, addB} + {{dataWidth{1'b0}}, addCin};
  end

  always_comb begin
    case (aluOp)
      opAdd,
      opAdc,
      opSub: begin
        wide = sum;
      end
      opAnd: begin
        wide = {1'b0, opA & opB};
      end
      opOr: begin
        wide = {1'b0, opA | opB};
      end
      opXor: begin
        wide = {1'b0, opA ^ opB};
      end
      opShl: begin
        wide = {opA, 1'b0}; // MSB of A lands in the carry position
      end
      opShr: begin
        wide = {opA[0], 1'b0, opA[dataWidth-1:1]}; // LSB of A goes to carry
      end
      opPassB: begin
        wide = {1'b0, opB};
      end
      default: begin
        wide = '0;
      end
    endcase
  end

  assign aluResult = wide[dataWidth-1:0];
  assign carryOut  = isLogicOp(aluOp) ? 1'b0 : wide[dataWidth];
  assign zeroOut   = (aluResult == '0);
  assign negOut    = aluResult[dataWidth-1]; // Sign bit of the result

endmodule

`default_nettype wire

// ==== regFile.sv ====
// regCount must be at least 16; reads are combinational and a pending write is bypassed to both ports
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuPkg::*; #(
  parameter int dataWidth = 16,
  parameter int regCount  = 16
) (
  input  wire                          clk,
  input  wire                          arstN,
  input  wire                          dataReg,  // Port A reads the data segment register
  input  wire                          stackReg, // Port A reads the stack pointer, port B reads zero
  input  wire [$clog2(regCount)-1:0]   readReg1,
  input  wire [$clog2(regCount)-1:0]   readReg2,
  input  wire                          wbEnable,
  input  wire [$clog2(regCount)-1:0]   wbAddr,
  input  wire [dataWidth-1:0]          wbData,
  output logic [dataWidth-1:0]         busA,
  output logic [dataWidth-1:0]         busB
);

  localparam int addrWidth = $clog2(regCount);

  logic [dataWidth-1:0] regs [regCount]; // 0 to 13 general, 14 data segment, 15 stack pointer
  logic [regCount-1:0]  writeSel;        // One-hot write select
  logic [addrWidth-1:0] idxA;            // Port A index after redirection

  // Write address decode, all zero when no write is pending
  always_comb begin
    writeSel = '0;
    if (wbEnable && (wbAddr < regCount)) begin
      writeSel[wbAddr] = 1'b1;
    end
  end

  // Register array with asynchronous clear
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < regCount; i++) begin
        if (writeSel[i]) begin
          regs[i] <= wbData;
        end
      end
    end
  end

  // Stored value, or the value about to be written when the addresses match
  function automatic logic [dataWidth-1:0] readPort(input logic [addrWidth-1:0] addr);
    logic [dataWidth-1:0] value;
    value = '0;
    if (wbEnable && (wbAddr == addr)) begin
      value = wbData; // Bypass for the instruction issued right after the producer
    end else if (addr < regCount) begin
      value = regs[addr];
    end
    return value;
  endfunction

  // Port A redirection, stack pointer has priority over data segment
  always_comb begin
    if (stackReg) begin
      idxA = addrWidth'(stackPtrIdx);
    end else if (dataReg) begin
      idxA = addrWidth'(dataSegIdx);
    end else begin
      idxA = readReg1;
    end
  end

  always_comb begin
    busA = readPort(idxA);
    if (stackReg) begin
      busB = '0; // Stack operations take a zero second operand
    end else begin
      busB = readPort(readReg2);
    end
  end

endmodule

`default_nettype wire

// ==== execStage.sv ====
// One cycle from issue to result and write-back; no stall, a new issue is accepted every cycle
`timescale 1ns/1ps
`default_nettype none

module execStage import cpuPkg::*; #(
  parameter int dataWidth = 16,
  parameter int regCount  = 16
) (
  input  wire                          clk,
  input  wire                          arstN,
  input  wire                          issue,     // One-cycle strobe per instruction
  input  wire                          regWrite,
  input  wire [$clog2(regCount)-1:0]   writeReg,
  input  wire aluOpT                   aluOp,
  input  wire                          useImm,
  input  wire [dataWidth-1:0]          immediate,
  input  wire [dataWidth-1:0]          busA,
  input  wire [dataWidth-1:0]          busB,
  output logic [dataWidth-1:0]         result,
  output logic                         resultValid,
  output logic                         flagZero,
  output logic                         flagCarry,
  output logic                         flagNeg,
  output logic                         wbEnable,
  output logic [$clog2(regCount)-1:0]  wbAddr,
  output logic [dataWidth-1:0]         wbData
);

  localparam int addrWidth = $clog2(regCount);

  logic [dataWidth-1:0] opB;
  logic [dataWidth-1:0] aluResult;
  logic                 carryOut;
  logic                 zeroOut;
  logic                 negOut;
  logic [dataWidth-1:0] resultQ;
  logic [addrWidth-1:0] writeRegQ;
  logic                 regWriteQ;
  logic                 validQ;

  assign opB = useImm ? immediate : busB;

  aluUnit #(
    .dataWidth(dataWidth)
  ) uAlu (
    .opA      (busA),
    .opB      (opB),
    .aluOp    (aluOp),
    .carryIn  (flagCarry), // Stored carry for add with carry chains
    .aluResult(aluResult),
    .carryOut (carryOut),
    .zeroOut  (zeroOut),
    .negOut   (negOut)
  );

  // Control and flags
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validQ    <= 1'b0;
      regWriteQ <= 1'b0;
      flagZero  <= 1'b0;
      flagCarry <= 1'b0;
      flagNeg   <= 1'b0;
    end else begin
      validQ <= issue;
      if (issue) begin
        regWriteQ <= regWrite;
        flagZero  <= zeroOut;
        flagCarry <= carryOut;
        flagNeg   <= negOut;
      end
    end
  end

  // Result pipeline register
  always_ff @(posedge clk) begin
    if (issue) begin
      resultQ   <= aluResult;
      writeRegQ <= writeReg;
    end
  end

  assign result      = resultQ;
  assign resultValid = validQ;
  assign wbData      = resultQ;
  assign wbAddr      = writeRegQ;
  assign wbEnable    = validQ & regWriteQ; // Register written at the next edge

endmodule

`default_nettype wire

// ==== datapathCore.sv ====
// Decoded control is taken as plain strobes and levels; regCount at least 16, dataWidth at least 4
`timescale 1ns/1ps
`default_nettype none

module datapathCore import cpuPkg::*; #(
  parameter int dataWidth = 16,
  parameter int regCount  = 16
) (
  input  wire                          clk,
  input  wire                          arstN,

  // Decoded instruction
  input  wire                          issue,
  input  wire                          regWrite,
  input  wire                          dataReg,
  input  wire                          stackReg,
  input  wire [$clog2(regCount)-1:0]   readReg1,
  input  wire [$clog2(regCount)-1:0]   readReg2,
  input  wire [$clog2(regCount)-1:0]   writeReg,
  input  wire aluOpT                   aluOp,
  input  wire                          useImm,
  input  wire [dataWidth-1:0]          immediate,

  // Execute results
  output logic [dataWidth-1:0]         result,
  output logic                         resultValid,
  output logic                         flagZero,
  output logic                         flagCarry,
  output logic                         flagNeg
);

  localparam int addrWidth = $clog2(regCount);

  // Operand buses, combinational from the register file
  logic [dataWidth-1:0] busA;
  logic [dataWidth-1:0] busB;

  // Write-back port
  logic                 wbEnable;
  logic [addrWidth-1:0] wbAddr;
  logic [dataWidth-1:0] wbData;

  regFile #(
    .dataWidth(dataWidth),
    .regCount (regCount)
  ) uRegFile (
    .clk     (clk),
    .arstN   (arstN),
    .dataReg (dataReg),
    .stackReg(stackReg),
    .readReg1(readReg1),
    .readReg2(readReg2),
    .wbEnable(wbEnable),
    .wbAddr  (wbAddr),
    .wbData  (wbData),
    .busA    (busA),
    .busB    (busB)
  );

  execStage #(
    .dataWidth(dataWidth),
    .regCount (regCount)
  ) uExec (
    .clk        (clk),
    .arstN      (arstN),
    .issue      (issue),
    .regWrite   (regWrite),
    .writeReg   (writeReg),
    .aluOp      (aluOp),
    .useImm     (useImm),
    .immediate  (immediate),
    .busA       (busA),
    .busB       (busB),
    .result     (result),
    .resultValid(resultValid),
    .flagZero   (flagZero),
    .flagCarry  (flagCarry),
    .flagNeg    (flagNeg),
    .wbEnable   (wbEnable),
    .wbAddr     (wbAddr),
    .wbData     (wbData)
  );

endmodule

`default_nettype wire

// ==== datapathCore_assert.sv ====
// Bound to every execStage instance; checks except the reset one are disabled while arstN is low
`timescale 1ns/1ps
`default_nettype none

module datapathCoreAssert (
  input wire clk,
  input wire arstN,
  input wire issue,
  input wire regWrite,
  input wire resultValid,
  input wire wbEnable
);

  // No register write in reset or on the first edge after it
  wbQuietInReset: assert property (@(posedge clk) (!arstN || $rose(arstN)) |-> !wbEnable)
    else $error("wbEnable high during reset or on the first edge after it");

  // Exactly one cycle of latency
  validAfterIssue: assert property (@(posedge clk) disable iff (!arstN) issue |=> resultValid)
    else $error("resultValid missing one cycle after issue");

  noValidWithoutIssue: assert property (@(posedge clk) disable iff (!arstN)
                                        !issue |=> !resultValid)
    else $error("resultValid high without an issue in the cycle before");

  // A write-back belongs to the valid result of an issue that had regWrite set
  wbOnlyWithValid: assert property (@(posedge clk) disable iff (!arstN)
                                    wbEnable |-> resultValid && $past(issue && regWrite))
    else $error("wbEnable high without a valid result of a writing issue");

endmodule

bind execStage datapathCoreAssert uAssert (
  .clk        (clk),
  .arstN      (arstN),
  .issue      (issue),
  .regWrite   (regWrite),
  .resultValid(resultValid),
  .wbEnable   (wbEnable)
);

`default_nettype wire

// ==== datapathCoreTb.sv ====
// Seed 84; inputs change 1 ns after the rising edge and results are sampled at the falling edge
`timescale 1ns/1ps
`default_nettype none

module datapathCoreTb import cpuPkg::*; #(
  parameter int dataWidth = 16,
  parameter int regCount  = 16
) ();

  localparam int clkPeriod = 8;
  localparam int addrWidth = $clog2(regCount);
  localparam int numChain  = 40;
  localparam int numRandom = 300;
  // Reset reads, write and two read sweeps, redirection, chain, random mix
  localparam int totalIssues = 4 * regCount + 6 + numChain + numRandom;

  typedef struct packed {
    logic [dataWidth-1:0] data;
    logic                 zero;
    logic                 carry;
    logic                 neg;
  } expectT;

  logic                 clk;
  logic                 arstN;
  logic                 issue;
  logic                 regWrite;
  logic                 dataReg;
  logic                 stackReg;
  logic [addrWidth-1:0] readReg1;
  logic [addrWidth-1:0] readReg2;
  logic [addrWidth-1:0] writeReg;
  aluOpT                aluOp;
  logic                 useImm;
  logic [dataWidth-1:0] immediate;
  logic [dataWidth-1:0] result;
  logic                 resultValid;
  logic                 flagZero;
  logic                 flagCarry;
  logic                 flagNeg;

  logic [dataWidth-1:0] shadow [regCount]; // Model of the register file
  logic                 shadowCarry;
  expectT               expQ [$];          // Results still to come out of the DUT
  expectT               lastFlags;         // Flags of the last compared result
  int                   checksPassed;
  int                   checksFailed;
  int                   testsFailed;

  datapathCore #(
    .dataWidth(dataWidth),
    .regCount (regCount)
  ) u_dut (
    .clk        (clk),
    .arstN      (arstN),
    .issue      (issue),
    .regWrite   (regWrite),
    .dataReg    (dataReg),
    .stackReg   (stackReg),
    .readReg1   (readReg1),
    .readReg2   (readReg2),
    .writeReg   (writeReg),
    .aluOp      (aluOp),
    .useImm     (useImm),
    .immediate  (immediate),
    .result     (result),
    .resultValid(resultValid),
    .flagZero   (flagZero),
    .flagCarry  (flagCarry),
    .flagNeg    (flagNeg)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Expected result and flags of one ALU operation
  function automatic expectT refAlu(input aluOpT op, input logic [dataWidth-1:0] a,
                                    input logic [dataWidth-1:0] b, input logic cin);
    expectT             e;
    logic [dataWidth:0] full; // Carry on top
    case (op)
      opAdd:   full = (dataWidth + 1)'(a) + (dataWidth + 1)'(b);
      opAdc:   full = (dataWidth + 1)'(a) + (dataWidth + 1)'(b) + (dataWidth + 1)'(cin);
      opSub:   full = {a >= b, a - b}; // Carry means no borrow
      opAnd:   full = {1'b0, a & b};
      opOr:    full = {1'b0, a | b};
      opXor:   full = {1'b0, a ^ b};
      opShl:   full = {a[dataWidth-1], a << 1};
      opShr:   full = {a[0], a >> 1};
      opPassB: full = {1'b0, b};
      default: full = '0;
    endcase
    e.data  = full[dataWidth-1:0];
    e.carry = full[dataWidth];
    e.zero  = (e.data == '0);
    e.neg   = e.data[dataWidth-1];
    return e;
  endfunction

  task automatic checkData(input string name, input logic [dataWidth-1:0] expected,
                           input logic [dataWidth-1:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
      checksFailed++;
    end else begin
      checksPassed++;
    end
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s expected %b actual %b", $time, name, expected, actual);
      checksFailed++;
    end else begin
      checksPassed++;
    end
  endtask

  // Drives one instruction for one cycle; the model updates at once, as the bypass does
  task automatic issueOp(input aluOpT op, input int rs1, input int rs2, input int rd,
                         input logic wr, input logic imm, input logic [dataWidth-1:0] immVal,
                         input logic ds, input logic sp);
    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] b;
    expectT               e;
    issue     = 1'b1;
    regWrite  = wr;
    dataReg   = ds;
    stackReg  = sp;
    readReg1  = addrWidth'(rs1);
    readReg2  = addrWidth'(rs2);
    writeReg  = addrWidth'(rd);
    aluOp     = op;
    useImm    = imm;
    immediate = immVal;
    a = sp ? shadow[stackPtrIdx] : (ds ? shadow[dataSegIdx] : shadow[rs1]);
    b = imm ? immVal : (sp ? '0 : shadow[rs2]);
    e = refAlu(op, a, b, shadowCarry);
    expQ.push_back(e);
    shadowCarry = e.carry;
    if (wr) begin
      shadow[rd] = e.data;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic idleCycles(input int n);
    issue    = 1'b0;
    regWrite = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Waits for outstanding results, then prints the test's line
  task automatic finishTest(input string name, input int failsBefore);
    int waited;
    waited = 0;
    issue    = 1'b0;
    regWrite = 1'b0;
    while (expQ.size() != 0 && waited < 8) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (expQ.size() != 0) begin
      $display("Test %s: %0d results never appeared on resultValid", name, expQ.size());
      checksFailed += expQ.size();
      expQ.delete();
    end
    if (checksFailed == failsBefore) begin
      $display("Test %s passed", name);
    end else begin
      $display("Test %s failed with %0d errors", name, checksFailed - failsBefore);
      testsFailed++;
    end
  endtask

  always @(negedge clk) begin : compareResults
    expectT e;
    if (arstN && resultValid) begin
      if (expQ.size() == 0) begin
        $display("At %0t ns resultValid was high with no instruction outstanding", $time);
        checksFailed++;
      end else begin
        e = expQ.pop_front();
        checkData("result", e.data, result);
        checkFlag("flagZero", e.zero, flagZero);
        checkFlag("flagCarry", e.carry, flagCarry);
        checkFlag("flagNeg", e.neg, flagNeg);
        lastFlags = e;
      end
    end else if (arstN) begin
      // No issue in the cycle before, so the flags hold
      checkFlag("flagZero", lastFlags.zero, flagZero);
      checkFlag("flagCarry", lastFlags.carry, flagCarry);
      checkFlag("flagNeg", lastFlags.neg, flagNeg);
    end
  end

  initial begin
    int    fails;
    int    prev;
    int    dst;
    aluOpT op;
    issue     = 1'b0;
    regWrite  = 1'b0;
    dataReg   = 1'b0;
    stackReg  = 1'b0;
    readReg1  = '0;
    readReg2  = '0;
    writeReg  = '0;
    aluOp     = opAdd;
    useImm    = 1'b0;
    immediate = '0;
    arstN     = 1'b0;
    checksPassed = 0;
    checksFailed = 0;
    testsFailed  = 0;
    shadowCarry  = 1'b0;
    lastFlags    = '0; // Flags are clear after reset
    for (int r = 0; r < regCount; r++) begin
      shadow[r] = '0;
    end
    void'($urandom(84));
    repeat (4) @(posedge clk);
    #1;
    arstN = 1'b1;

    fails = checksFailed; // Reset state
    repeat (4) begin
      checkFlag("resultValid", 1'b0, resultValid);
      checkFlag("flagCarry", 1'b0, flagCarry);
      checkFlag("flagZero", 1'b0, flagZero);
      checkFlag("flagNeg", 1'b0, flagNeg);
      @(posedge clk);
      #1;
    end
    for (int r = 0; r < regCount; r++) begin
      issueOp(opPassB, 0, r, 0, 1'b0, 1'b0, '0, 1'b0, 1'b0);
    end
    finishTest("reset state", fails);

    fails = checksFailed;
    for (int r = 0; r < regCount; r++) begin
      issueOp(opPassB, 0, 0, r, 1'b1, 1'b1, dataWidth'($urandom), 1'b0, 1'b0);
    end
    for (int r = 0; r < regCount; r++) begin
      issueOp(opPassB, 0, r, 0, 1'b0, 1'b0, '0, 1'b0, 1'b0); // Port B
    end
    for (int r = 0; r < regCount; r++) begin
      issueOp(opAdd, r, 0, 0, 1'b0, 1'b1, '0, 1'b0, 1'b0);   // Port A plus zero
    end
    finishTest("write and read-back", fails);

    fails = checksFailed;
    issueOp(opAdd, 3, 0, 0, 1'b0, 1'b1, '0, 1'b0, 1'b1);    // Stack pointer on port A
    issueOp(opPassB, 0, 5, 0, 1'b0, 1'b0, '0, 1'b0, 1'b1);  // Port B forced to zero
    issueOp(opAdd, 7, 0, 0, 1'b0, 1'b1, '0, 1'b1, 1'b0);    // Data segment on port A
    issueOp(opAdd, 2, 9, 0, 1'b0, 1'b0, '0, 1'b1, 1'b0);
    issueOp(opPassB, 0, 0, stackPtrIdx, 1'b1, 1'b1, dataWidth'($urandom), 1'b0, 1'b0);
    issueOp(opAdd, 0, 0, 0, 1'b0, 1'b1, '0, 1'b0, 1'b1);    // New stack pointer via bypass
    finishTest("special redirection", fails);

    fails = checksFailed;
    prev = 0;
    for (int i = 0; i < numChain; i++) begin
      dst = $urandom_range(0, 13);
      issueOp(aluOpT'($urandom_range(0, 8)), prev, $urandom_range(0, 13), dst, 1'b1,
              1'($urandom_range(0, 1)), dataWidth'($urandom), 1'b0, 1'b0);
      prev = dst; // Next instruction reads this destination
    end
    finishTest("back-to-back dependency", fails);

    fails = checksFailed;
    for (int i = 0; i < numRandom; i++) begin
      if ((i % 12) >= 7 && (i % 12) <= 10) begin
        op = opAdc; // Carry chain over the flag left by the op before
      end else begin
        op = aluOpT'($urandom_range(0, 8));
      end
      issueOp(op, $urandom_range(0, 15), $urandom_range(0, 15), $urandom_range(0, 13),
              1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)), dataWidth'($urandom),
              ($urandom_range(0, 15) == 0), ($urandom_range(0, 15) == 0));
      if ($urandom_range(0, 15) == 0) begin
        idleCycles(1); // Flags must hold across a gap
      end
    end
    finishTest("ALU operations and flags", fails);

    $display("Checks passed: %0d, checks failed: %0d, tests failed: %0d",
             checksPassed, checksFailed, testsFailed);
    if (checksFailed == 0 && testsFailed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #((totalIssues + 200) * clkPeriod);
    $display("Timeout: the tests did not finish within %0d clock cycles", totalIssues + 200);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
cpuPkg.sv
aluUnit.sv
regFile.sv
execStage.sv
datapathCore.sv
datapathCore_assert.sv
datapathCoreTb.sv

// ==== Makefile ====
# Verilator build and run of the datapath testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module datapathCoreTb -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/VdatapathCoreTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
